// ==== frontend_decode.f ====
logic/riscv_pkg.sv
logic/offnariscv_pkg.sv
logic/axis_sync_fifo.sv
logic/decoder.sv
logic/rf_read_stage.sv
logic/frontend_decode.sv
tb/tb_clkgen.sv
tb/frontend_decode_assert.sv
tb/frontend_decode_tb.sv

// ==== tb/frontend_decode_tb.sv ====
// ====================================================================
// Decode front end testbench with a random RV32I stream and a model
// ====================================================================
`timescale 1ns/1ns

module frontend_decode_tb
  import riscv_pkg::*, offnariscv_pkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int CLK_NS     = 4;
  localparam int N_RANDOM   = 300;
  localparam int N_GAPPY    = 60;
  localparam int N_FLUSHED  = 20;
  // Reset, register preload, streams at up to 2 cycles per gappy item,
  // two fills and a margin for drains and the directed tests
  localparam int STIM_CYCLES = 16 + 32 + N_RANDOM + 2 * (N_GAPPY + N_FLUSHED) +
                               2 * 2 * FIFO_DEPTH + 40;

  logic        clk;
  logic        arst_n;
  logic        if_valid;
  logic        if_ready;
  ifid_tdata_t if_data;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        ex_valid;
  logic        ex_ready;
  rfex_tdata_t ex_data;
  logic        invalidate;

  logic [31:0] mregs [32];    // Model register file
  ifid_tdata_t model_q [$];   // Fetched words still in flight
  logic [31:0] pc;
  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;
  int          accept_cyc;
  int          pop_cyc;

  tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(16)) u_clkgen (.clk(clk), .arst_n(arst_n));

  frontend_decode #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_frontend_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .if_valid   (if_valid),
    .if_ready   (if_ready),
    .if_data    (if_data),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .ex_valid   (ex_valid),
    .ex_ready   (ex_ready),
    .ex_data    (ex_data),
    .invalidate (invalidate)
  );

  task automatic check(string what, logic [127:0] got, logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Reference decode, written from the RV32I field layouts
  function automatic idrf_tdata_t model_decode(ifid_tdata_t f);
    idrf_tdata_t d;
    logic [31:0] i;
    logic [4:0]  op;
    logic [2:0]  f3;
    i = f.inst;
    op = i[6:2];
    f3 = i[14:12];
    d = '0;
    d.if_data = f;
    if (op inside {OP, AMO, LOAD, OP_IMM, JALR, STORE, BRANCH}) d.rs1 = i[19:15];
    if (op inside {OP, AMO, STORE, BRANCH}) d.rs2 = i[24:20];
    if (op inside {OP, AMO, LOAD, OP_IMM, JALR, LUI, AUIPC, JAL}) d.rd = i[11:7];
    case (op)
      LOAD, OP_IMM, JALR: d.immediate = 32'($signed(i[31:20]));
      STORE:      d.immediate = 32'($signed({i[31:25], i[11:7]}));
      BRANCH:     d.immediate = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
      LUI, AUIPC: d.immediate = {i[31:12], 12'h000};
      JAL:        d.immediate = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
      default: ;
    endcase
    d.alu_cmd_vld = op inside {OP_IMM, OP, LUI, AUIPC};
    d.alu_cmd = ADD;
    if (op == OP || op == OP_IMM) begin
      case (f3)
        3'd0: d.alu_cmd = (op == OP && i[30]) ? SUB : ADD;
        3'd1: d.alu_cmd = SLL;
        3'd2: d.alu_cmd = SLT;
        3'd3: d.alu_cmd = SLTU;
        3'd4: d.alu_cmd = XOR;
        3'd5: d.alu_cmd = i[30] ? SRA : SRL;
        3'd6: d.alu_cmd = OR;
        3'd7: d.alu_cmd = AND;
      endcase
    end
    d.bru_cmd_vld = op inside {BRANCH, JAL, JALR};
    d.bru_cmd = (op == JAL) ? BRU_JAL : (op == JALR) ? BRU_JALR : BRU_BEQ;
    if (op == BRANCH) begin
      case (f3)
        3'd1: d.bru_cmd = BRU_BNE;
        3'd4: d.bru_cmd = BRU_BLT;
        3'd5: d.bru_cmd = BRU_BGE;
        3'd6: d.bru_cmd = BRU_BLTU;
        3'd7: d.bru_cmd = BRU_BGEU;
        default: d.bru_cmd = BRU_BEQ;
      endcase
    end
    d.illegal = (i[1:0] != 2'b11) ||
                !(op inside {LOAD, OP_IMM, AUIPC, STORE, AMO, OP, LUI, BRANCH, JALR, JAL}) ||
                (op == BRANCH && (f3 == 3'd2 || f3 == 3'd3));
    return d;
  endfunction

  function automatic logic [31:0] rand_inst();
    opcode_e     ops [10];
    logic [31:0] w;
    ops = '{LOAD, OP_IMM, AUIPC, STORE, AMO, OP, LUI, BRANCH, JALR, JAL};
    w = $urandom;
    w[6:0] = {ops[$urandom_range(9)], 2'b11};
    case ($urandom_range(15))
      0: w[1:0] = 2'($urandom_range(2)); // Compressed-looking low bits
      1: w[6:2] = 5'b11100;              // SYSTEM, outside the subset
      default: ;
    endcase
    return w;
  endfunction

  task automatic compare_pop();
    idrf_tdata_t d;
    if (model_q.size() == 0) begin
      errors++;
      $display("Extra packet on ex at %0t ns while nothing is expected", $time);
      return;
    end
    d = model_decode(model_q.pop_front());
    check("pc and inst", ex_data.id_data.if_data, d.if_data);
    check("rs1 rs2 rd", {ex_data.id_data.rs1, ex_data.id_data.rs2, ex_data.id_data.rd},
          {d.rs1, d.rs2, d.rd});
    check("immediate", ex_data.id_data.immediate, d.immediate);
    check("alu cmd", {ex_data.id_data.alu_cmd_vld, ex_data.id_data.alu_cmd},
          {d.alu_cmd_vld, d.alu_cmd});
    check("bru cmd", {ex_data.id_data.bru_cmd_vld, ex_data.id_data.bru_cmd},
          {d.bru_cmd_vld, d.bru_cmd});
    check("illegal", ex_data.id_data.illegal, d.illegal);
    check("rs1_val", ex_data.rs1_val, mregs[d.rs1]);
    check("rs2_val", ex_data.rs2_val, mregs[d.rs2]);
  endtask

  // Transfers seen at each edge, before the DUT state moves
  always @(posedge clk) begin
    cyc++;
    if (arst_n) begin
      if (invalidate) begin
        model_q.delete();
      end else begin
        if (ex_valid && ex_ready) begin
          compare_pop();
          pop_cyc = cyc;
        end
        if (if_valid && if_ready) begin
          model_q.push_back(if_data);
          accept_cyc = cyc;
        end
      end
      if (wb_en && wb_rd != 5'd0) mregs[wb_rd] = wb_data; // x0 stays zero
    end
  end

  // All stimulus tasks start and end 1 ns after a rising edge
  task automatic send(logic [31:0] inst);
    if_data = '{pc: pc, inst: inst};
    if_valid = 1'b1;
    pc += 32'd4;
    do @(posedge clk); while (!if_ready);
    #1 if_valid = 1'b0;
  endtask

  task automatic wb_write(logic [4:0] rd, logic [31:0] data);
    wb_en = 1'b1;
    wb_rd = rd;
    wb_data = data;
    @(posedge clk);
    #1 wb_en = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    ex_ready = 1'b1;
    while (model_q.size() != 0 && waited < 100) begin
      @(posedge clk);
      #1 waited++;
    end
    if (model_q.size() != 0) begin
      errors++;
      $display("Pipe did not drain, %0d packets never reached ex", model_q.size());
    end
  endtask

  task automatic stream(int n, bit gappy);
    bit busy;
    busy = 1'b1;
    fork
      begin
        repeat (n) send(rand_inst());
        busy = 1'b0;
      end
      while (busy) begin
        ex_ready = gappy ? ($urandom_range(3) != 0) : 1'b1;
        @(posedge clk);
        #1;
      end
    join
    drain();
  endtask

  task automatic fill(output int n);
    n = 0;
    ex_ready = 1'b0;
    while (if_ready && n < 4 * FIFO_DEPTH) begin
      send(rand_inst());
      n++;
    end
  endtask

  task automatic report(string name, int err_before);
    $display("Test %s: %0d errors", name, errors - err_before);
  endtask

  initial begin
    #(STIM_CYCLES * CLK_NS * 4);
    $display("Watchdog expired at %0t ns, the run stopped making progress", $time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int e0;
    int n_acc;
    void'($urandom(32'hbc9));
    if_valid = 1'b0;
    if_data = '0;
    wb_en = 1'b0;
    wb_rd = '0;
    wb_data = '0;
    ex_ready = 1'b1;
    invalidate = 1'b0;
    pc = 32'h0000_1000;
    foreach (mregs[r]) mregs[r] = '0;

    @(posedge arst_n);
    @(posedge clk);
    #1 e0 = errors;
    check("ex_valid after reset", ex_valid, 1'b0);
    check("if_ready after reset", if_ready, 1'b1);
    report("reset state", e0);

    e0 = errors;
    for (int r = 0; r < 32; r++) wb_write(5'(r), $urandom);
    stream(N_RANDOM, 1'b0);
    report("random decode", e0);

    e0 = errors;
    fill(n_acc);
    check("accepted before if_ready fell", n_acc, 2 * FIFO_DEPTH);
    stream(N_GAPPY, 1'b1);
    report("back-pressure", e0);

    e0 = errors;
    send({7'd0, 5'd0, 5'd5, 3'd0, 5'd1, 7'b0110011}); // add x1, x5, x0
    wb_write(5'd5, $urandom);                          // Lands on the read edge
    drain();
    wb_write(5'd0, 32'hffff_ffff);
    send({12'h7ff, 5'd0, 3'd0, 5'd2, 7'b0010011});     // addi x2, x0, 2047
    wb_write(5'd0, 32'h1234_5678);
    drain();
    report("bypass and x0", e0);

    e0 = errors;
    send({12'h001, 5'd3, 3'd0, 5'd3, 7'b0010011});
    drain();
    check("accept to ex latency", pop_cyc - accept_cyc, 2);
    fill(n_acc);
    invalidate = 1'b1;
    @(posedge clk);
    #1 invalidate = 1'b0;
    @(posedge clk);
    check("ex_valid after flush", ex_valid, 1'b0);
    #1 stream(N_FLUSHED, 1'b1);
    report("latency and flush", e0);

    errors += u_frontend_decode.u_assert.fail_count;
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/frontend_decode_assert.sv ====
// ====================================================================
// Stream handshake and reset checks on the decode front end top level
// ====================================================================
`timescale 1ns/1ns

module frontend_decode_assert
  import offnariscv_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        if_valid,
  input logic        if_ready,
  input logic        ex_valid,
  input logic        ex_ready,
  input rfex_tdata_t ex_data,
  input logic        invalidate
);

  int fail_count = 0; // Failed assertions so far

  // A source keeps valid up to its transfer
  assert property (@(posedge clk) disable iff (!arst_n || invalidate)
    if_valid && !if_ready |=> if_valid)
    else begin
      fail_count++;
      $error("if_valid dropped before transfer");
    end

  assert property (@(posedge clk) disable iff (!arst_n || invalidate)
    ex_valid && !ex_ready |=> ex_valid)
    else begin
      fail_count++;
      $error("ex_valid dropped before transfer");
    end

  assert property (@(posedge clk) disable iff (!arst_n || invalidate)
    ex_valid && !ex_ready |=> $stable(ex_data))
    else begin
      fail_count++;
      $error("ex_data changed while stalled");
    end

  // Quiet output and open input right after reset
  assert property (@(posedge clk) $rose(arst_n) |=> !ex_valid)
    else begin
      fail_count++;
      $error("ex_valid in the cycle after reset");
    end

  assert property (@(posedge clk) $rose(arst_n) |-> if_ready)
    else begin
      fail_count++;
      $error("if_ready low after reset");
    end

endmodule

bind frontend_decode frontend_decode_assert u_assert (
  .clk        (clk),
  .arst_n     (arst_n),
  .if_valid   (if_valid),
  .if_ready   (if_ready),
  .ex_valid   (ex_valid),
  .ex_ready   (ex_ready),
  .ex_data    (ex_data),
  .invalidate (invalidate)
);

// ==== tb/tb_clkgen.sv ====
// ====================================================================
// Testbench clock and active low reset source
// ====================================================================
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1; // Released just after an edge
  end

endmodule

// ==== logic/frontend_decode.sv ====
// ====================================================================
// Front end decode top: decoder followed by register read stage
// ====================================================================
`timescale 1ns/1ns

module frontend_decode
  import riscv_pkg::*, offnariscv_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,

  input  logic                  if_valid,
  output logic                  if_ready,
  input  ifid_tdata_t           if_data,

  input  logic                  wb_en,
  input  logic [REG_ADDR_W-1:0] wb_rd,
  input  logic [XLEN-1:0]       wb_data,

  output logic                  ex_valid,
  input  logic                  ex_ready,
  output rfex_tdata_t           ex_data,

  input  logic                  invalidate  // Flush pulse for both FIFOs
);

  logic        idrf_valid;
  logic        idrf_ready;
  idrf_tdata_t idrf_data;

  decoder #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .if_valid   (if_valid),
    .if_ready   (if_ready),
    .if_data    (if_data),
    .idrf_valid (idrf_valid),
    .idrf_ready (idrf_ready),
    .idrf_data  (idrf_data),
    .invalidate (invalidate)
  );

  rf_read_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rf_read_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .idrf_valid (idrf_valid),
    .idrf_ready (idrf_ready),
    .idrf_data  (idrf_data),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .ex_valid   (ex_valid),
    .ex_ready   (ex_ready),
    .ex_data    (ex_data),
    .invalidate (invalidate)
  );

endmodule

// ==== logic/rf_read_stage.sv ====
// ====================================================================
// Register read: 32x32 register file, write-back bypass, output FIFO
// ====================================================================
`timescale 1ns/1ns

module rf_read_stage
  import riscv_pkg::*, offnariscv_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,

  input  logic                  idrf_valid,
  output logic                  idrf_ready,
  input  idrf_tdata_t           idrf_data,

  input  logic                  wb_en,
  input  logic [REG_ADDR_W-1:0] wb_rd,
  input  logic [XLEN-1:0]       wb_data,

  output logic                  ex_valid,
  input  logic                  ex_ready,
  output rfex_tdata_t           ex_data,

  input  logic                  invalidate
);

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  rfex_tdata_t     rf_pkt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin // Writes to x0 dropped
      regs[wb_rd] <= wb_data;
    end
  end

  // Read ports, a same-cycle write-back to the index wins
  assign rs1_val = (idrf_data.rs1 == '0) ? '0 :
                   (wb_en && wb_rd == idrf_data.rs1) ? wb_data : regs[idrf_data.rs1];
  assign rs2_val = (idrf_data.rs2 == '0) ? '0 :
                   (wb_en && wb_rd == idrf_data.rs2) ? wb_data : regs[idrf_data.rs2];

  always_comb begin
    rf_pkt         = '0;
    rf_pkt.id_data = idrf_data;
    rf_pkt.rs1_val = rs1_val;
    rf_pkt.rs2_val = rs2_val;
  end

  // Operands captured at the idrf transfer edge
  axis_sync_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .T_DATA (rfex_tdata_t)
  ) u_rfex_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (idrf_valid),
    .in_ready   (idrf_ready),
    .in_data    (rf_pkt),
    .out_valid  (ex_valid),
    .out_ready  (ex_ready),
    .out_data   (ex_data),
    .invalidate (invalidate)
  );

endmodule

// ==== logic/decoder.sv ====
// ====================================================================
// RV32I decoder: fields, immediate and unit commands into a FIFO
// ====================================================================
`timescale 1ns/1ns

module decoder
  import riscv_pkg::*, offnariscv_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        arst_n,

  input  logic        if_valid,   // From fetch
  output logic        if_ready,
  input  ifid_tdata_t if_data,

  output logic        idrf_valid, // To register read
  input  logic        idrf_ready,
  output idrf_tdata_t idrf_data,

  input  logic        invalidate
);

  logic [XLEN-1:0] inst;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            funct7_b5;
  logic            opcode_known;
  idrf_tdata_t     dec;

  assign inst      = if_data.inst;
  assign opcode    = opcode_e'(inst[6:2]);
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30]; // SUB and SRA select

  assign opcode_known = opcode inside {LOAD, OP_IMM, AUIPC, STORE, AMO,
                                       OP, LUI, BRANCH, JALR, JAL};

  always_comb begin
    dec           = '0; // Fields a format lacks stay zero
    dec.if_data   = if_data;

    // Register indices and immediate per format
    case (opcode)
      OP, AMO: begin
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];
      end
      LOAD, OP_IMM, JALR: begin
        dec.rs1       = inst[19:15];
        dec.rd        = inst[11:7];
        dec.immediate = {{20{inst[31]}}, inst[31:20]};
      end
      STORE: begin
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      BRANCH: begin
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      LUI, AUIPC: begin
        dec.rd        = inst[11:7];
        dec.immediate = {inst[31:12], 12'b0};
      end
      JAL: begin
        dec.rd        = inst[11:7];
        dec.immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: ;
    endcase

    // ALU command
    dec.alu_cmd_vld = opcode inside {OP_IMM, AUIPC, OP, LUI};
    dec.alu_cmd     = ADD;
    if (opcode inside {OP_IMM, OP}) begin
      case (funct3)
        3'b000:  dec.alu_cmd = (opcode == OP && funct7_b5) ? SUB : ADD;
        3'b001:  dec.alu_cmd = SLL;
        3'b010:  dec.alu_cmd = SLT;
        3'b011:  dec.alu_cmd = SLTU;
        3'b100:  dec.alu_cmd = XOR;
        3'b101:  dec.alu_cmd = funct7_b5 ? SRA : SRL;
        3'b110:  dec.alu_cmd = OR;
        default: dec.alu_cmd = AND;
      endcase
    end

    // Branch unit command
    dec.bru_cmd_vld = opcode inside {BRANCH, JAL, JALR};
    dec.bru_cmd     = BRU_BEQ;
    case (opcode)
      BRANCH: begin
        case (funct3)
          3'b001:  dec.bru_cmd = BRU_BNE;
          3'b100:  dec.bru_cmd = BRU_BLT;
          3'b101:  dec.bru_cmd = BRU_BGE;
          3'b110:  dec.bru_cmd = BRU_BLTU;
          3'b111:  dec.bru_cmd = BRU_BGEU;
          default: dec.bru_cmd = BRU_BEQ; // 010 and 011 flagged below
        endcase
      end
      JAL:     dec.bru_cmd = BRU_JAL;
      JALR:    dec.bru_cmd = BRU_JALR;
      default: ;
    endcase

    dec.illegal = (inst[1:0] != 2'b11) || !opcode_known ||
                  (opcode == BRANCH && funct3 inside {3'b010, 3'b011});
  end

  axis_sync_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .T_DATA (idrf_tdata_t)
  ) u_idrf_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (if_valid),
    .in_ready   (if_ready),
    .in_data    (dec),
    .out_valid  (idrf_valid),
    .out_ready  (idrf_ready),
    .out_data   (idrf_data),
    .invalidate (invalidate)
  );

endmodule

// ==== logic/axis_sync_fifo.sv ====
// ====================================================================
// Synchronous valid/ready FIFO, generic payload type, with flush
// ====================================================================
`timescale 1ns/1ns

module axis_sync_fifo #(
  parameter int  DEPTH  = 4,
  parameter type T_DATA = logic [31:0]
) (
  input  logic  clk,
  input  logic  arst_n,

  input  logic  in_valid,
  output logic  in_ready,
  input  T_DATA in_data,

  output logic  out_valid,
  input  logic  out_ready,
  output T_DATA out_data,

  input  logic  invalidate
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointer increment with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH)); // No pass-through when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (invalidate) begin // Flush wins over a push
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/offnariscv_pkg.sv ====
// ====================================================================
// Front end pipeline payloads with ALU and branch unit command codes
// ====================================================================

package offnariscv_pkg;

  // ALU operations
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_cmd_e;

  // Branch unit operations
  typedef enum logic [2:0] {
    BRU_BEQ  = 3'd0,
    BRU_BNE  = 3'd1,
    BRU_BLT  = 3'd2,
    BRU_BGE  = 3'd3,
    BRU_BLTU = 3'd4,
    BRU_BGEU = 3'd5,
    BRU_JAL  = 3'd6,
    BRU_JALR = 3'd7
  } bru_cmd_e;

  // Fetch to decode
  typedef struct packed {
    logic [riscv_pkg::XLEN-1:0] pc;
    logic [riscv_pkg::XLEN-1:0] inst;
  } ifid_tdata_t;

  // Decode to register read
  typedef struct packed {
    ifid_tdata_t                      if_data;
    logic [riscv_pkg::REG_ADDR_W-1:0] rs1;
    logic [riscv_pkg::REG_ADDR_W-1:0] rs2;
    logic [riscv_pkg::REG_ADDR_W-1:0] rd;
    logic [riscv_pkg::XLEN-1:0]       immediate;
    logic                             alu_cmd_vld;
    logic                             bru_cmd_vld;
    alu_cmd_e                         alu_cmd;
    bru_cmd_e                         bru_cmd;
    logic                             illegal;
  } idrf_tdata_t;

  // Register read to execute
  typedef struct packed {
    idrf_tdata_t                id_data;
    logic [riscv_pkg::XLEN-1:0] rs1_val;
    logic [riscv_pkg::XLEN-1:0] rs2_val;
  } rfex_tdata_t;

endpackage

// ==== logic/riscv_pkg.sv ====
// ====================================================================
// RV32I ISA definitions: word and register index widths, major opcodes
// ====================================================================

package riscv_pkg;

  // Data word width
  localparam int XLEN = 32;

  // Register index width, 32 architectural registers
  localparam int REG_ADDR_W = 5;

  // Major opcode, instruction bits 6 to 2
  // Bits 1 to 0 are always 11 for 32-bit encodings
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,
    OP_IMM = 5'b00_100,
    AUIPC  = 5'b00_101,
    STORE  = 5'b01_000,
    AMO    = 5'b01_011,
    OP     = 5'b01_100,
    LUI    = 5'b01_101,
    BRANCH = 5'b11_000,
    JALR   = 5'b11_001,
    JAL    = 5'b11_011
  } opcode_e;

  // Other opcode values, such as MISC_MEM and SYSTEM, are
  // outside the supported subset and decode as illegal

endpackage
